// File: files.f
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/dec_ex_if.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/rv_pipe_core.sv
verif/tb_rv_pipe_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build the pipeline testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv_pipe_core \
    --Mdir obj_dir -o tb_rv_pipe_core \
    -f files.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_rv_pipe_core)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF 'All tests passed!'; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: verif/tb_rv_pipe_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_pipe_core;

    localparam int         clk_period   = 100;
    localparam int         reset_cycles = 10;
    localparam logic [6:0] bad_opcode   = 7'b1111111;
    localparam logic [6:0] bad_funct7   = 7'b0000001;   // M-extension form

    logic                  clk;
    logic                  arst_n;
    logic                  instr_valid;
    rv_isa_pkg::instr_t    instr;
    logic                  wb_valid;
    rv_isa_pkg::reg_addr_t wb_rd;
    rv_isa_pkg::xlen_t     wb_data;
    logic                  illegal;

    // One row per instruction
    rv_isa_pkg::instr_t    tbl_instr[$];
    logic                  tbl_legal[$];
    rv_isa_pkg::reg_addr_t tbl_rd[$];
    rv_isa_pkg::xlen_t     tbl_data[$];

    rv_isa_pkg::xlen_t     model_regs [32];
    integer                seed         = 32'h6a26_29da;
    int                    errors       = 0;
    int                    failed_tests = 0;
    bit                    table_built  = 1'b0;

    rv_pipe_core UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .illegal     (illegal)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic rv_isa_pkg::reg_addr_t rand_reg();
        return rv_isa_pkg::reg_addr_t'(1 + {$random(seed)} % 31);   // Never x0
    endfunction

    function automatic rv_isa_pkg::instr_t r_type(logic [6:0] f7, logic [2:0] f3,
                                                  rv_isa_pkg::reg_addr_t rd,
                                                  rv_isa_pkg::reg_addr_t rs1,
                                                  rv_isa_pkg::reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::opcode_op};
    endfunction

    function automatic rv_isa_pkg::instr_t i_type(logic [11:0] imm, logic [2:0] f3,
                                                  rv_isa_pkg::reg_addr_t rd,
                                                  rv_isa_pkg::reg_addr_t rs1);
        return {imm, rs1, f3, rd, rv_isa_pkg::opcode_op_imm};
    endfunction

    // ALU function as the ISA defines it
    function automatic rv_isa_pkg::xlen_t isa_result(logic [2:0] f3, logic alt,
                                                     rv_isa_pkg::xlen_t a,
                                                     rv_isa_pkg::xlen_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            rv_isa_pkg::f3_add_sub: return alt ? a - b : a + b;
            rv_isa_pkg::f3_sll:     return a << sh;
            rv_isa_pkg::f3_slt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_isa_pkg::f3_sltu:    return (a < b) ? 32'd1 : 32'd0;
            rv_isa_pkg::f3_xor:     return a ^ b;
            rv_isa_pkg::f3_srl_sra: // Sign fill built from a mask
                return (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0);
            rv_isa_pkg::f3_or:      return a | b;
            default:                return a & b;
        endcase
    endfunction

    task automatic predict(input rv_isa_pkg::instr_t ins, output logic legal,
                           output rv_isa_pkg::xlen_t data);
        logic [6:0]        op;
        logic [6:0]        f7;
        logic [2:0]        f3;
        logic              shift;
        logic              alt;
        rv_isa_pkg::xlen_t a;
        rv_isa_pkg::xlen_t b;
        op    = ins[6:0];
        f3    = ins[14:12];
        f7    = ins[31:25];
        shift = f3 == rv_isa_pkg::f3_sll || f3 == rv_isa_pkg::f3_srl_sra;
        alt   = f7 == rv_isa_pkg::funct7_alt;
        a     = model_regs[ins[19:15]];
        if (op == rv_isa_pkg::opcode_op)
        begin
            legal = f7 == rv_isa_pkg::funct7_base
                    || (alt && (f3 == rv_isa_pkg::f3_add_sub || f3 == rv_isa_pkg::f3_srl_sra));
            b = model_regs[ins[24:20]];
        end
        else if (op == rv_isa_pkg::opcode_op_imm)
        begin
            legal = !shift || f7 == rv_isa_pkg::funct7_base
                    || (alt && f3 == rv_isa_pkg::f3_srl_sra);
            b     = {{20{ins[31]}}, ins[31:20]};
            alt   = alt && f3 == rv_isa_pkg::f3_srl_sra;   // Only SRAI
        end
        else
        begin
            legal = 1'b0;
            b     = '0;
        end
        data = isa_result(f3, alt, a, b);
    endtask

    task automatic add_entry(input rv_isa_pkg::instr_t ins);
        logic              legal;
        rv_isa_pkg::xlen_t data;
        predict(ins, legal, data);
        tbl_instr.push_back(ins);
        tbl_legal.push_back(legal);
        tbl_rd.push_back(ins[11:7]);
        tbl_data.push_back(data);
        if (legal && ins[11:7] != 5'd0)
            model_regs[ins[11:7]] = data;
    endtask

    task automatic build_table();
        rv_isa_pkg::reg_addr_t rd;
        logic [2:0]            f3;
        logic [11:0]           imm;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        add_entry(r_type(rv_isa_pkg::funct7_base, rv_isa_pkg::f3_or, rand_reg(), 5'd3, 5'd7));
        for (int round = 0; round < 2; round++)
        begin
            // Immediate forms, each read back by an ADD
            for (int k = 0; k < 9; k++)
            begin
                f3  = (k < 8) ? 3'(k) : rv_isa_pkg::f3_srl_sra;
                imm = 12'($random(seed));
                if (f3 == rv_isa_pkg::f3_sll || f3 == rv_isa_pkg::f3_srl_sra)
                    imm[11:5] = (k == 8) ? rv_isa_pkg::funct7_alt : rv_isa_pkg::funct7_base;
                rd = rand_reg();
                add_entry(i_type(imm, f3, rd, rand_reg()));
                add_entry(r_type(rv_isa_pkg::funct7_base, rv_isa_pkg::f3_add_sub,
                                 rand_reg(), rd, 5'd0));
            end
            for (int k = 0; k < 10; k++)
            begin
                f3 = (k < 8) ? 3'(k) : ((k == 8) ? rv_isa_pkg::f3_add_sub : rv_isa_pkg::f3_srl_sra);
                add_entry(r_type((k < 8) ? rv_isa_pkg::funct7_base : rv_isa_pkg::funct7_alt,
                                 f3, rand_reg(), rand_reg(), rand_reg()));
            end
            add_entry(i_type(12'($random(seed)), rv_isa_pkg::f3_add_sub, 5'd0, rand_reg()));
            add_entry(r_type(rv_isa_pkg::funct7_base, rv_isa_pkg::f3_or, rand_reg(), 5'd0, 5'd0));
            // Illegal ones, then a read of their rd
            rd = rand_reg();
            add_entry({20'($random(seed)), rd, bad_opcode});
            add_entry(r_type(rv_isa_pkg::funct7_base, rv_isa_pkg::f3_add_sub, rand_reg(), rd, 5'd0));
            rd = rand_reg();
            add_entry(r_type(bad_funct7, rv_isa_pkg::f3_add_sub, rd, rand_reg(), rand_reg()));
            add_entry(r_type(rv_isa_pkg::funct7_base, rv_isa_pkg::f3_add_sub, rand_reg(), rd, 5'd0));
        end
        table_built = 1'b1;
    endtask

    task automatic check_data(string name, rv_isa_pkg::xlen_t got, rv_isa_pkg::xlen_t exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_rd(string name, rv_isa_pkg::reg_addr_t got,
                            rv_isa_pkg::reg_addr_t exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    initial
    begin
        int errors_before;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        build_table();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("illegal", illegal, 1'b0);
        for (int i = 0; i < tbl_instr.size(); i++)
        begin
            errors_before = errors;
            instr_valid   = 1'b1;
            instr         = tbl_instr[i];
            @(posedge clk);   // Sampling edge
            for (int c = 0; c <= rv_core_pkg::pipe_latency; c++)
            begin
                @(negedge clk);
                instr_valid = 1'b0;
                if (c == rv_core_pkg::pipe_latency - 1)
                begin
                    check_flag("wb_valid", wb_valid, tbl_legal[i]);
                    check_flag("illegal", illegal, !tbl_legal[i]);
                    if (tbl_legal[i])
                    begin
                        check_rd("wb_rd", wb_rd, tbl_rd[i]);
                        check_data("wb_data", wb_data, tbl_data[i]);
                    end
                end
                else
                begin
                    check_flag("wb_valid", wb_valid, 1'b0);   // Quiet outside result cycle
                    check_flag("illegal", illegal, 1'b0);
                end
            end
            if (errors == errors_before)
                $display("test %0d instr %h ok", i, tbl_instr[i]);
            else
            begin
                failed_tests++;
                $display("test %0d instr %h failed", i, tbl_instr[i]);
            end
        end
        $display("%0d tests, %0d failed, %0d mismatches", tbl_instr.size(), failed_tests, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // Watchdog sized from the table length
    initial
    begin
        wait (table_built);
        #((reset_cycles + tbl_instr.size() * (rv_core_pkg::pipe_latency + 1) + 20)
          * clk_period);
        $display("watchdog expired before all table entries were applied");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/rv_pipe_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_core (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  instr_valid,
    input  wire rv_isa_pkg::instr_t    instr,
    output logic                       wb_valid,
    output rv_isa_pkg::reg_addr_t      wb_rd,
    output rv_isa_pkg::xlen_t          wb_data,
    output logic                       illegal
);

    dec_ex_if dx ();

    logic                  illegal_d;
    logic                  ex_valid, ex_illegal;
    rv_isa_pkg::reg_addr_t ex_rd;
    rv_isa_pkg::xlen_t     ex_data;
    logic                  wr_en;       // Write-back loop into decode
    rv_isa_pkg::reg_addr_t wr_addr;
    rv_isa_pkg::xlen_t     wr_data;

    decode_stage u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .dx          (dx.source),
        .illegal_d   (illegal_d)
    );

    execute_stage u_execute (
        .clk        (clk),
        .arst_n     (arst_n),
        .dx         (dx.sink),
        .illegal_d  (illegal_d),
        .ex_valid   (ex_valid),
        .ex_illegal (ex_illegal),
        .ex_rd      (ex_rd),
        .ex_data    (ex_data)
    );

    result_stage u_result (
        .clk        (clk),
        .arst_n     (arst_n),
        .ex_valid   (ex_valid),
        .ex_illegal (ex_illegal),
        .ex_rd      (ex_rd),
        .ex_data    (ex_data),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .illegal    (illegal),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

endmodule

`default_nettype wire

// File: src/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  ex_valid,
    input  wire logic                  ex_illegal,
    input  wire rv_isa_pkg::reg_addr_t ex_rd,
    input  wire rv_isa_pkg::xlen_t     ex_data,
    output logic                       wb_valid,
    output rv_isa_pkg::reg_addr_t      wb_rd,
    output rv_isa_pkg::xlen_t          wb_data,
    output logic                       illegal,
    output logic                       wr_en,
    output rv_isa_pkg::reg_addr_t      wr_addr,
    output rv_isa_pkg::xlen_t          wr_data
);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_valid <= 1'b0;
            illegal  <= 1'b0;
        end
        else
        begin
            wb_valid <= ex_valid;
            illegal  <= ex_illegal;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_rd   <= ex_rd;
        wb_data <= ex_data;
    end

    // Bank write from the same register as the ports
    assign wr_en   = wb_valid;
    assign wr_addr = wb_rd;
    assign wr_data = wb_data;

    a_wb_not_illegal: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(wb_valid && illegal)
    );

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire logic           clk,
    input  wire logic           arst_n,
    dec_ex_if.sink              dx,
    input  wire logic           illegal_d,
    output logic                ex_valid,
    output logic                ex_illegal,
    output rv_isa_pkg::reg_addr_t ex_rd,
    output rv_isa_pkg::xlen_t   ex_data
);

    rv_isa_pkg::xlen_t                  op_a, op_b, alu_result;
    logic [rv_isa_pkg::shamt_w-1:0]     shamt;

    assign op_a  = dx.rs1_data;
    assign op_b  = dx.use_imm ? dx.imm : dx.rs2_data;   // ALU source mux
    assign shamt = op_b[rv_isa_pkg::shamt_w-1:0];

    always_comb
    begin
        case (dx.alu_op)
            rv_core_pkg::alu_add:  alu_result = op_a + op_b;
            rv_core_pkg::alu_sub:  alu_result = op_a - op_b;
            rv_core_pkg::alu_sll:  alu_result = op_a << shamt;
            rv_core_pkg::alu_slt:  alu_result = rv_isa_pkg::xlen_t'($signed(op_a) < $signed(op_b));
            rv_core_pkg::alu_sltu: alu_result = rv_isa_pkg::xlen_t'(op_a < op_b);
            rv_core_pkg::alu_xor:  alu_result = op_a ^ op_b;
            rv_core_pkg::alu_srl:  alu_result = op_a >> shamt;
            rv_core_pkg::alu_sra:  alu_result = rv_isa_pkg::xlen_t'($signed(op_a) >>> shamt);
            rv_core_pkg::alu_or:   alu_result = op_a | op_b;
            rv_core_pkg::alu_and:  alu_result = op_a & op_b;
            default:               alu_result = '0;   // Unused encodings
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ex_valid   <= 1'b0;
            ex_illegal <= 1'b0;
        end
        else
        begin
            ex_valid   <= dx.valid;
            ex_illegal <= illegal_d;   // Carried alongside, no ALU work
        end
    end

    always_ff @(posedge clk)
    begin
        ex_rd   <= dx.rd;
        ex_data <= alu_result;
    end

    // Decode must classify each strobe one way only
    a_valid_xor_illegal: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(dx.valid && illegal_d)
    );

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  instr_valid,
    input  wire rv_isa_pkg::instr_t    instr,
    input  wire logic                  wr_en,
    input  wire rv_isa_pkg::reg_addr_t wr_addr,
    input  wire rv_isa_pkg::xlen_t     wr_data,
    dec_ex_if.source                   dx,
    output logic                       illegal_d
);

    logic [rv_isa_pkg::opcode_w-1:0] opcode;
    logic [rv_isa_pkg::funct3_w-1:0] funct3;
    logic [rv_isa_pkg::funct7_w-1:0] funct7;
    logic [rv_isa_pkg::imm_w-1:0]    imm_field;
    rv_isa_pkg::reg_addr_t           rd, rs1_addr, rs2_addr;
    rv_isa_pkg::xlen_t               rs1_data, rs2_data, imm;
    rv_core_pkg::alu_op_e            alu_op;
    logic                            is_op, is_imm, f7_base, f7_alt, is_shift, legal;

    assign opcode    = instr[rv_isa_pkg::opcode_lsb +: rv_isa_pkg::opcode_w];
    assign rd        = instr[rv_isa_pkg::rd_lsb     +: rv_isa_pkg::reg_addr_w];
    assign funct3    = instr[rv_isa_pkg::funct3_lsb +: rv_isa_pkg::funct3_w];
    assign rs1_addr  = instr[rv_isa_pkg::rs1_lsb    +: rv_isa_pkg::reg_addr_w];
    assign rs2_addr  = instr[rv_isa_pkg::rs2_lsb    +: rv_isa_pkg::reg_addr_w];
    assign funct7    = instr[rv_isa_pkg::funct7_lsb +: rv_isa_pkg::funct7_w];
    assign imm_field = instr[rv_isa_pkg::imm_lsb    +: rv_isa_pkg::imm_w];

    assign is_op    = opcode == rv_isa_pkg::opcode_op;
    assign is_imm   = opcode == rv_isa_pkg::opcode_op_imm;
    assign f7_base  = funct7 == rv_isa_pkg::funct7_base;
    assign f7_alt   = funct7 == rv_isa_pkg::funct7_alt;
    assign is_shift = funct3 == rv_isa_pkg::f3_sll || funct3 == rv_isa_pkg::f3_srl_sra;

    // Shift-immediates take the shamt, others sign-extend
    assign imm = is_shift ? rv_isa_pkg::xlen_t'(imm_field[rv_isa_pkg::shamt_w-1:0])
                          : {{(rv_isa_pkg::xlen-rv_isa_pkg::imm_w){imm_field[11]}}, imm_field};

    // Merged main and ALU control
    always_comb
    begin
        alu_op = rv_core_pkg::alu_add;
        legal  = 1'b0;
        case (funct3)
            rv_isa_pkg::f3_add_sub:
            begin
                alu_op = (is_op && f7_alt) ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
                legal  = is_imm || f7_base || f7_alt;   // ADDI has no funct7
            end
            rv_isa_pkg::f3_sll:  begin alu_op = rv_core_pkg::alu_sll;  legal = f7_base; end
            rv_isa_pkg::f3_slt:  begin alu_op = rv_core_pkg::alu_slt;  legal = is_imm || f7_base; end
            rv_isa_pkg::f3_sltu: begin alu_op = rv_core_pkg::alu_sltu; legal = is_imm || f7_base; end
            rv_isa_pkg::f3_xor:  begin alu_op = rv_core_pkg::alu_xor;  legal = is_imm || f7_base; end
            rv_isa_pkg::f3_srl_sra:
            begin
                alu_op = f7_alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
                legal  = f7_base || f7_alt;
            end
            rv_isa_pkg::f3_or:   begin alu_op = rv_core_pkg::alu_or;   legal = is_imm || f7_base; end
            default:             begin alu_op = rv_core_pkg::alu_and;  legal = is_imm || f7_base; end
        endcase
        legal = legal && (is_op || is_imm);   // Unknown opcodes
    end

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            dx.valid  <= 1'b0;
            illegal_d <= 1'b0;
        end
        else
        begin
            dx.valid  <= instr_valid && legal;
            illegal_d <= instr_valid && !legal;
        end
    end

    // Payload, qualified by valid
    always_ff @(posedge clk)
    begin
        dx.rd       <= rd;
        dx.alu_op   <= alu_op;
        dx.use_imm  <= is_imm;
        dx.rs1_data <= rs1_data;
        dx.rs2_data <= rs2_data;
        dx.imm      <= imm;
    end

    a_instr_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        instr_valid |-> !$isunknown(instr)
    );

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire rv_isa_pkg::reg_addr_t rs1_addr,
    input  wire rv_isa_pkg::reg_addr_t rs2_addr,
    output rv_isa_pkg::xlen_t          rs1_data,
    output rv_isa_pkg::xlen_t          rs2_data,
    input  wire logic                  wr_en,
    input  wire rv_isa_pkg::reg_addr_t wr_addr,
    input  wire rv_isa_pkg::xlen_t     wr_data
);

    rv_isa_pkg::xlen_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_en && wr_addr != '0)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Reads are combinational, x0 forced to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // Write port comes from the result stage
    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr_en |-> !$isunknown(wr_addr)
    );

endmodule

`default_nettype wire

// File: src/dec_ex_if.sv
`timescale 1ns/1ps
`default_nettype none

// One decoded instruction, decode to execute
interface dec_ex_if;
    logic                    valid;     // Legal instruction present
    rv_isa_pkg::reg_addr_t   rd;
    rv_core_pkg::alu_op_e    alu_op;
    logic                    use_imm;   // Second operand from imm
    rv_isa_pkg::xlen_t       rs1_data;
    rv_isa_pkg::xlen_t       rs2_data;
    rv_isa_pkg::xlen_t       imm;

    modport source (
        output valid, rd, alu_op, use_imm, rs1_data, rs2_data, imm
    );

    modport sink (
        input  valid, rd, alu_op, use_imm, rs1_data, rs2_data, imm
    );
endinterface

`default_nettype wire

// File: src/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    // ALU operations, one per RV32I ALU function
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,   // Signed compare
        alu_sltu = 4'd4,   // Unsigned compare
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // Edges from the sampling edge of instr to the edge that
    // sees wb_valid or illegal high
    //   decode register  N
    //   execute register N+1
    //   result register  N+2
    localparam int pipe_latency = 3;

endpackage

`default_nettype wire

// File: src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Data path and register index widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;
    localparam int funct7_w   = 7;
    localparam int imm_w      = 12;
    localparam int shamt_w    = 5;   // Shift amount in I-type shifts

    typedef logic [xlen-1:0]       xlen_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [31:0]           instr_t;

    // Field positions, lsb of each field
    localparam int opcode_lsb = 0;
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int imm_lsb    = 20;
    localparam int funct7_lsb = 25;

    localparam logic [opcode_w-1:0] opcode_op     = 7'b0110011;  // R-type ALU
    localparam logic [opcode_w-1:0] opcode_op_imm = 7'b0010011;  // I-type ALU

    localparam logic [funct3_w-1:0] f3_add_sub = 3'b000;
    localparam logic [funct3_w-1:0] f3_sll     = 3'b001;
    localparam logic [funct3_w-1:0] f3_slt     = 3'b010;
    localparam logic [funct3_w-1:0] f3_sltu    = 3'b011;
    localparam logic [funct3_w-1:0] f3_xor     = 3'b100;
    localparam logic [funct3_w-1:0] f3_srl_sra = 3'b101;
    localparam logic [funct3_w-1:0] f3_or      = 3'b110;
    localparam logic [funct3_w-1:0] f3_and     = 3'b111;

    localparam logic [funct7_w-1:0] funct7_base = 7'b0000000;
    localparam logic [funct7_w-1:0] funct7_alt  = 7'b0100000;  // SUB and SRA/SRAI

endpackage

`default_nettype wire
